// ==== fu_pkg.sv ====
package fu_pkg;

  // Basic widths
  typedef logic [63:0] word_t;  // Operand / result word
  typedef logic [5:0]  tag_t;   // Destination physical register tag

  // ALU operations, reference order without multiply
  // 5 bits wide so undefined codes exist and hit the poison default
  typedef enum logic [4:0] {
    ALU_ADDQ   = 5'd0,
    ALU_SUBQ   = 5'd1,
    ALU_AND    = 5'd2,
    ALU_BIC    = 5'd3,
    ALU_BIS    = 5'd4,
    ALU_ORNOT  = 5'd5,
    ALU_XOR    = 5'd6,
    ALU_EQV    = 5'd7,
    ALU_SRL    = 5'd8,
    ALU_SLL    = 5'd9,
    ALU_SRA    = 5'd10,
    ALU_CMPULT = 5'd11,
    ALU_CMPEQ  = 5'd12,
    ALU_CMPULE = 5'd13,
    ALU_CMPLT  = 5'd14,
    ALU_CMPLE  = 5'd15
  } alu_func_e;

  // Branch condition, [1:0] picks the test, [2] inverts
  typedef logic [2:0] br_func_t;

  typedef struct packed {
    alu_func_e func;
    word_t     opa;
    word_t     opb;
    tag_t      tag;
  } alu_req_s;

  typedef struct packed {
    word_t opa;
    word_t opb;
    tag_t  tag;
  } mult_req_s;

  typedef struct packed {
    br_func_t func;
    word_t    opa;   // Register under test
    word_t    pc;
    word_t    disp;  // Word displacement, already sign extended
    tag_t     tag;
  } br_req_s;

  // What a unit holds for the arbiter
  typedef struct packed {
    tag_t  tag;
    word_t value;
    logic  br_taken;   // Zero outside the branch unit
    word_t br_target;
  } fu_result_s;

  // Common data bus
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t value;
    logic  br_taken;
    word_t br_target;
  } cdb_s;

  localparam int NUM_UNITS = 3;

  // Request / grant bit positions
  localparam int UNIT_ALU  = 0;
  localparam int UNIT_MULT = 1;
  localparam int UNIT_BR   = 2;

endpackage

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               issue,    // One cycle strobe
  input  fu_pkg::alu_req_s   req_in,
  output logic               busy,
  output logic               req,      // To CDB arbiter
  input  logic               gnt,
  output fu_pkg::fu_result_s result
);

  fu_pkg::word_t value;   // Combinational ALU output
  logic          req_q;   // Hold register full
  fu_pkg::tag_t  tag_q;
  fu_pkg::word_t value_q;

  // Signed less-than built from the sign bits
  function automatic logic signed_lt(fu_pkg::word_t a, fu_pkg::word_t b);
    if (a[63] == b[63])
      return a < b;  // Same sign, unsigned compare works
    return a[63];    // Negative side is smaller
  endfunction

  always_comb begin
    case (req_in.func)
      fu_pkg::ALU_ADDQ:   value = req_in.opa + req_in.opb;
      fu_pkg::ALU_SUBQ:   value = req_in.opa - req_in.opb;
      fu_pkg::ALU_AND:    value = req_in.opa & req_in.opb;
      fu_pkg::ALU_BIC:    value = req_in.opa & ~req_in.opb;
      fu_pkg::ALU_BIS:    value = req_in.opa | req_in.opb;
      fu_pkg::ALU_ORNOT:  value = req_in.opa | ~req_in.opb;
      fu_pkg::ALU_XOR:    value = req_in.opa ^ req_in.opb;
      fu_pkg::ALU_EQV:    value = req_in.opa ^ ~req_in.opb;
      fu_pkg::ALU_SRL:    value = req_in.opa >> req_in.opb[5:0];
      fu_pkg::ALU_SLL:    value = req_in.opa << req_in.opb[5:0];
      fu_pkg::ALU_SRA:    value = (req_in.opa >> req_in.opb[5:0]) |
                                  ({64{req_in.opa[63]}} << (7'd64 - {1'b0, req_in.opb[5:0]}));
      fu_pkg::ALU_CMPULT: value = {63'd0, req_in.opa < req_in.opb};
      fu_pkg::ALU_CMPEQ:  value = {63'd0, req_in.opa == req_in.opb};
      fu_pkg::ALU_CMPULE: value = {63'd0, req_in.opa <= req_in.opb};
      fu_pkg::ALU_CMPLT:  value = {63'd0, signed_lt(req_in.opa, req_in.opb)};
      fu_pkg::ALU_CMPLE:  value = {63'd0, signed_lt(req_in.opa, req_in.opb) ||
                                          (req_in.opa == req_in.opb)};
      default:            value = 64'hdeadbeefbaadbeef;  // Undefined func, poison
    endcase
  end

  // Full flag, cleared on grant unless refilled the same edge
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else if (issue) begin
      req_q <= 1'b1;
    end else if (gnt) begin
      req_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      tag_q   <= req_in.tag;
      value_q <= value;
    end
  end

  assign req  = req_q;
  assign busy = req_q & ~gnt;  // Free again in the grant cycle

  assign result = '{tag: tag_q, value: value_q, br_taken: 1'b0, br_target: '0};

  // Issuer must respect busy
  a_no_issue_busy: assert property (@(posedge clock) disable iff (!rst_n)
    issue |-> !busy) else $error("alu issued while busy");

  // Waiting result must not change under the arbiter
  a_hold_stable: assert property (@(posedge clock) disable iff (!rst_n)
    req && !gnt |=> $stable(result)) else $error("alu result changed while waiting");

endmodule

// ==== mult_unit.sv ====
`timescale 1ns/1ps

module mult_unit #(
  parameter int MULT_STAGES = 4  // 2 or more
) (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               issue,
  input  fu_pkg::mult_req_s  req_in,
  output logic               busy,
  output logic               req,
  input  logic               gnt,
  output fu_pkg::fu_result_s result
);

  // Multiplier bits handled per stage, rounded up
  localparam int CHUNK = (64 + MULT_STAGES - 1) / MULT_STAGES;

  // Payload carried down the pipe
  typedef struct packed {
    fu_pkg::tag_t  tag;
    fu_pkg::word_t opa;
    fu_pkg::word_t opb;
    fu_pkg::word_t acc;  // Partial sum so far
  } stage_s;

  logic [MULT_STAGES-1:0] vld;              // Per stage valid
  stage_s                 stg [MULT_STAGES];
  logic                   stall;            // Last stage waiting on grant

  // One partial product, opb slice idx, shifted into place
  function automatic fu_pkg::word_t partial(fu_pkg::word_t a, fu_pkg::word_t b, int idx);
    fu_pkg::word_t mask;
    fu_pkg::word_t slice;
    mask  = (fu_pkg::word_t'(1) << CHUNK) - fu_pkg::word_t'(1);
    slice = (b >> (idx * CHUNK)) & mask;
    return (a * slice) << (idx * CHUNK);  // Low 64 bits only
  endfunction

  assign stall = vld[MULT_STAGES-1] & ~gnt;

  // Valid bits shift as one, frozen by stall
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else if (!stall) begin
      vld <= {vld[MULT_STAGES-2:0], issue};
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      // Stage 0 takes slice 0 straight from issue
      stg[0].tag <= req_in.tag;
      stg[0].opa <= req_in.opa;
      stg[0].opb <= req_in.opb;
      stg[0].acc <= partial(req_in.opa, req_in.opb, 0);
      for (int i = 1; i < MULT_STAGES; i++) begin
        stg[i].tag <= stg[i-1].tag;
        stg[i].opa <= stg[i-1].opa;
        stg[i].opb <= stg[i-1].opb;
        stg[i].acc <= stg[i-1].acc + partial(stg[i-1].opa, stg[i-1].opb, i);  // Slice i
      end
    end
  end

  assign req  = vld[MULT_STAGES-1];
  assign busy = stall;  // Frozen pipe cannot take stage 0

  assign result = '{tag:       stg[MULT_STAGES-1].tag,
                    value:     stg[MULT_STAGES-1].acc,
                    br_taken:  1'b0,
                    br_target: '0};

  // Issue into a frozen pipe would overwrite stage 0
  a_no_issue_busy: assert property (@(posedge clock) disable iff (!rst_n)
    issue |-> !busy) else $error("mult_unit issued while busy");

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               issue,
  input  fu_pkg::br_req_s    req_in,
  output logic               busy,
  output logic               req,
  input  logic               gnt,
  output fu_pkg::fu_result_s result
);

  logic          cond;      // Condition after invert
  fu_pkg::word_t link;      // pc + 4
  fu_pkg::word_t target;
  logic          req_q;
  fu_pkg::tag_t  tag_q;
  fu_pkg::word_t link_q;
  logic          taken_q;
  fu_pkg::word_t target_q;

  always_comb begin
    case (req_in.func[1:0])
      2'b00: cond = ~req_in.opa[0];                          // Low bit clear
      2'b01: cond = (req_in.opa == '0);                      // Equal zero
      2'b10: cond = req_in.opa[63];                          // Negative
      default: cond = req_in.opa[63] || (req_in.opa == '0);  // Less or equal zero
    endcase
    if (req_in.func[2])
      cond = ~cond;  // NE / GE / GT / bit set forms
  end

  assign link   = req_in.pc + 64'd4;
  assign target = link + (req_in.disp << 2);  // Displacement in words

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else if (issue) begin
      req_q <= 1'b1;
    end else if (gnt) begin
      req_q <= 1'b0;  // Result left on the CDB
    end
  end

  // Payload, no reset
  always_ff @(posedge clock) begin
    if (issue) begin
      tag_q    <= req_in.tag;
      link_q   <= link;
      taken_q  <= cond;
      target_q <= target;
    end
  end

  assign req  = req_q;
  assign busy = req_q & ~gnt;

  assign result = '{tag: tag_q, value: link_q, br_taken: taken_q, br_target: target_q};

  a_no_issue_busy: assert property (@(posedge clock) disable iff (!rst_n)
    issue |-> !busy) else $error("branch_unit issued while busy");

endmodule

// ==== cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
  input  logic                          clock,
  input  logic                          rst_n,
  input  logic [fu_pkg::NUM_UNITS-1:0]  req,
  input  fu_pkg::fu_result_s            results [fu_pkg::NUM_UNITS],
  output logic [fu_pkg::NUM_UNITS-1:0]  gnt,
  output fu_pkg::cdb_s                  cdb
);

  localparam int N  = fu_pkg::NUM_UNITS;
  localparam int PW = $clog2(N);

  logic [PW-1:0] ptr;    // First unit to look at
  logic [PW-1:0] win;    // Winner this cycle
  logic          found;

  // Search req starting at ptr, wrapping
  always_comb begin
    int idx;
    gnt   = '0;
    win   = ptr;
    found = 1'b0;
    for (int i = 0; i < N; i++) begin
      idx = (int'(ptr) + i) % N;
      if (!found && req[idx]) begin
        found    = 1'b1;
        win      = PW'(idx);
        gnt[idx] = 1'b1;
      end
    end
  end

  // Next search starts just past the winner
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= PW'(fu_pkg::UNIT_ALU);
    end else if (found) begin
      ptr <= (int'(win) == N - 1) ? '0 : win + 1'b1;
    end
  end

  always_comb begin
    cdb = '0;  // Idle bus reads as all zero
    if (found) begin
      cdb.valid     = 1'b1;
      cdb.tag       = results[win].tag;
      cdb.value     = results[win].value;
      cdb.br_taken  = results[win].br_taken;
      cdb.br_target = results[win].br_target;
    end
  end

  a_gnt_onehot: assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0(gnt)) else $error("more than one CDB grant");

  a_gnt_subset: assert property (@(posedge clock) disable iff (!rst_n)
    (gnt & ~req) == '0) else $error("CDB grant without request");

endmodule

// ==== fu_cluster.sv ====
`timescale 1ns/1ps

module fu_cluster #(
  parameter int MULT_STAGES = 4
) (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              alu_issue,
  input  fu_pkg::alu_req_s  alu_req,
  output logic              alu_busy,
  input  logic              mult_issue,
  input  fu_pkg::mult_req_s mult_req,
  output logic              mult_busy,
  input  logic              br_issue,
  input  fu_pkg::br_req_s   br_req,
  output logic              br_busy,
  output fu_pkg::cdb_s      cdb
);

  logic [fu_pkg::NUM_UNITS-1:0] req;                         // Unit requests
  logic [fu_pkg::NUM_UNITS-1:0] gnt;                         // One-hot grants
  fu_pkg::fu_result_s           results [fu_pkg::NUM_UNITS]; // Held results

  alu alu_i (
    .clock  (clock),
    .rst_n  (rst_n),
    .issue  (alu_issue),
    .req_in (alu_req),
    .busy   (alu_busy),
    .req    (req[fu_pkg::UNIT_ALU]),
    .gnt    (gnt[fu_pkg::UNIT_ALU]),
    .result (results[fu_pkg::UNIT_ALU])
  );

  mult_unit #(
    .MULT_STAGES (MULT_STAGES)
  ) mult_i (
    .clock  (clock),
    .rst_n  (rst_n),
    .issue  (mult_issue),
    .req_in (mult_req),
    .busy   (mult_busy),
    .req    (req[fu_pkg::UNIT_MULT]),
    .gnt    (gnt[fu_pkg::UNIT_MULT]),
    .result (results[fu_pkg::UNIT_MULT])
  );

  branch_unit br_i (
    .clock  (clock),
    .rst_n  (rst_n),
    .issue  (br_issue),
    .req_in (br_req),
    .busy   (br_busy),
    .req    (req[fu_pkg::UNIT_BR]),
    .gnt    (gnt[fu_pkg::UNIT_BR]),
    .result (results[fu_pkg::UNIT_BR])
  );

  cdb_arbiter arb_i (
    .clock   (clock),
    .rst_n   (rst_n),
    .req     (req),
    .results (results),
    .gnt     (gnt),
    .cdb     (cdb)
  );

endmodule

// ==== tb_fu_cluster.sv ====
`timescale 1ns/1ps

module tb_fu_cluster;

  localparam int MULT_STAGES = 4;
  localparam int NUM_RANDOM  = 300;
  localparam int N           = fu_pkg::NUM_UNITS;

  // One table entry, b doubles as pc for branches
  typedef struct packed {
    int            unit;
    logic [4:0]    func;
    fu_pkg::word_t a;
    fu_pkg::word_t b;
    fu_pkg::word_t disp;
    fu_pkg::word_t ev;  // Expected CDB value
    logic          et;  // Expected taken
    fu_pkg::word_t eg;  // Expected target
  } row_s;

  logic              clock;
  logic              rst_n;
  logic              alu_issue;
  fu_pkg::alu_req_s  alu_req;
  logic              alu_busy;
  logic              mult_issue;
  fu_pkg::mult_req_s mult_req;
  logic              mult_busy;
  logic              br_issue;
  fu_pkg::br_req_s   br_req;
  logic              br_busy;
  fu_pkg::cdb_s      cdb;

  row_s          rows [$];
  logic          pending  [64];  // Scoreboard by tag
  fu_pkg::word_t sb_val   [64];
  logic          sb_taken [64];
  fu_pkg::word_t sb_tgt   [64];
  fu_pkg::tag_t  next_tag;
  int            n_pending;
  int            n_issued;
  int            n_done;
  logic          issued_any;     // Set by the first issue
  int            cycles;
  int            limit;
  int            wait_cnt [N];   // Cycles a request has waited
  logic [63:0]   rng;

  fu_cluster #(
    .MULT_STAGES (MULT_STAGES)
  ) dut_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .alu_issue  (alu_issue),
    .alu_req    (alu_req),
    .alu_busy   (alu_busy),
    .mult_issue (mult_issue),
    .mult_req   (mult_req),
    .mult_busy  (mult_busy),
    .br_issue   (br_issue),
    .br_req     (br_req),
    .br_busy    (br_busy),
    .cdb        (cdb)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [63:0] xorshift(input logic [63:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 7);
    s = s ^ (s << 17);
    return s;
  endfunction

  // Expected ALU value
  function automatic fu_pkg::word_t alu_model(input logic [4:0] f, input fu_pkg::word_t a,
                                              input fu_pkg::word_t b);
    case (f)
      fu_pkg::ALU_ADDQ:   return a + b;
      fu_pkg::ALU_SUBQ:   return a - b;
      fu_pkg::ALU_AND:    return a & b;
      fu_pkg::ALU_BIC:    return a & ~b;
      fu_pkg::ALU_BIS:    return a | b;
      fu_pkg::ALU_ORNOT:  return a | ~b;
      fu_pkg::ALU_XOR:    return a ^ b;
      fu_pkg::ALU_EQV:    return ~(a ^ b);
      fu_pkg::ALU_SRL:    return a >> b[5:0];
      fu_pkg::ALU_SLL:    return a << b[5:0];
      fu_pkg::ALU_SRA:    return $signed(a) >>> b[5:0];
      fu_pkg::ALU_CMPULT: return {63'd0, a < b};
      fu_pkg::ALU_CMPEQ:  return {63'd0, a == b};
      fu_pkg::ALU_CMPULE: return {63'd0, a <= b};
      fu_pkg::ALU_CMPLT:  return {63'd0, $signed(a) < $signed(b)};
      fu_pkg::ALU_CMPLE:  return {63'd0, $signed(a) <= $signed(b)};
      default:            return 64'hdeadbeefbaadbeef;
    endcase
  endfunction

  // Taken flag per branch code
  function automatic logic br_model(input logic [2:0] f, input fu_pkg::word_t a);
    logic t;
    case (f[1:0])
      2'd0:    t = (a[0] == 1'b0);
      2'd1:    t = (a == 64'd0);
      2'd2:    t = ($signed(a) < 0);
      default: t = ($signed(a) <= 0);
    endcase
    return f[2] ? !t : t;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check(input string name, input fu_pkg::word_t got, input fu_pkg::word_t exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      fail_run("value check failed");
    end
  endtask

  task automatic add_row(input int unit, input int func, input fu_pkg::word_t a,
                         input fu_pkg::word_t b, input fu_pkg::word_t disp,
                         input fu_pkg::word_t ev, input logic et, input fu_pkg::word_t eg);
    row_s r;
    r.unit = unit;
    r.func = 5'(func);
    r.a    = a;
    r.b    = b;
    r.disp = disp;
    r.ev   = ev;
    r.et   = et;
    r.eg   = eg;
    rows.push_back(r);
  endtask

  // Step to the next falling edge, strobes last one cycle
  task automatic next_cycle();
    @(negedge clock);
    alu_issue  = 1'b0;
    mult_issue = 1'b0;
    br_issue   = 1'b0;
  endtask

  function automatic logic unit_blocked(input int unit);
    case (unit)
      fu_pkg::UNIT_ALU:  return alu_busy || alu_issue;
      fu_pkg::UNIT_MULT: return mult_busy || mult_issue;
      default:           return br_busy || br_issue;
    endcase
  endfunction

  // Issue in the current cycle once the unit and the tag are free
  task automatic issue_op(input int unit, input logic [4:0] func, input fu_pkg::word_t a,
                          input fu_pkg::word_t b, input fu_pkg::word_t disp,
                          input fu_pkg::word_t ev, input logic et, input fu_pkg::word_t eg);
    while (unit_blocked(unit) || pending[next_tag])
      next_cycle();
    case (unit)
      fu_pkg::UNIT_ALU: begin
        alu_issue = 1'b1;
        alu_req   = '{func: fu_pkg::alu_func_e'(func), opa: a, opb: b, tag: next_tag};
      end
      fu_pkg::UNIT_MULT: begin
        mult_issue = 1'b1;
        mult_req   = '{opa: a, opb: b, tag: next_tag};
      end
      default: begin
        br_issue = 1'b1;
        br_req   = '{func: func[2:0], opa: a, pc: b, disp: disp, tag: next_tag};
      end
    endcase
    pending[next_tag]  = 1'b1;
    sb_val[next_tag]   = ev;
    sb_taken[next_tag] = et;
    sb_tgt[next_tag]   = eg;
    n_pending++;
    n_issued++;
    issued_any = 1'b1;
    next_tag   = next_tag + 6'd1;  // Wraps at 64
  endtask

  // CDB monitor, sampled at the rising edge
  always @(posedge clock) begin
    fu_pkg::tag_t t;
    t = cdb.tag;
    if (rst_n) begin
      if (!issued_any) begin  // Quiet until the first issue
        check("cdb.valid", fu_pkg::word_t'(cdb.valid), '0);
        check("alu_busy", fu_pkg::word_t'(alu_busy), '0);
        check("mult_busy", fu_pkg::word_t'(mult_busy), '0);
        check("br_busy", fu_pkg::word_t'(br_busy), '0);
      end
      if (cdb.valid && !pending[t]) begin
        fail_run($sformatf("CDB returned tag %0d that is not outstanding", t));
      end else if (cdb.valid) begin
        check("cdb.value", cdb.value, sb_val[t]);
        check("cdb.br_taken", fu_pkg::word_t'(cdb.br_taken), fu_pkg::word_t'(sb_taken[t]));
        check("cdb.br_target", cdb.br_target, sb_tgt[t]);
        pending[t] = 1'b0;
        n_pending--;
        n_done++;
      end
      for (int u = 0; u < N; u++) begin
        if (dut_i.req[u] && !dut_i.gnt[u])
          wait_cnt[u]++;
        else
          wait_cnt[u] = 0;
        if (wait_cnt[u] > N)
          fail_run($sformatf("unit %0d waited more than %0d grants for the CDB", u, N));
      end
      if (mult_busy && !(dut_i.req[fu_pkg::UNIT_MULT] && !dut_i.gnt[fu_pkg::UNIT_MULT]))
        fail_run("mult_busy high while the multiplier pipe is not frozen");
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > limit)
      fail_run("timeout, issued results never arrived on the CDB");
  end

  initial begin
    int            unit;
    logic [4:0]    f;
    fu_pkg::word_t a;
    fu_pkg::word_t b;
    fu_pkg::word_t d;
    fu_pkg::word_t ev;
    fu_pkg::word_t eg;
    logic          et;
    rst_n      = 1'b0;
    alu_issue  = 1'b0;
    mult_issue = 1'b0;
    br_issue   = 1'b0;
    alu_req    = '0;
    mult_req   = '0;
    br_req     = '0;
    next_tag   = '0;
    n_pending  = 0;
    n_issued   = 0;
    n_done     = 0;
    issued_any = 1'b0;
    cycles     = 0;
    rng        = 64'd18;
    for (int i = 0; i < 64; i++)
      pending[i] = 1'b0;
    for (int u = 0; u < N; u++)
      wait_cnt[u] = 0;

    // ALU: unit 0, func code in enum order
    add_row(0, 0, 64'd5, 64'd7, '0, 64'd12, 1'b0, '0);
    add_row(0, 0, 64'hffffffffffffffff, 64'd1, '0, '0, 1'b0, '0);          // Wraps
    add_row(0, 1, 64'd3, 64'd5, '0, 64'hfffffffffffffffe, 1'b0, '0);
    add_row(0, 2, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, '0, 64'hf000f000f000f000, 1'b0, '0);
    add_row(0, 3, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, '0, 64'h00f000f000f000f0, 1'b0, '0);
    add_row(0, 4, 64'h00000000000000ff, 64'hff00000000000000, '0, 64'hff000000000000ff, 1'b0, '0);
    add_row(0, 5, '0, 64'hffffffff00000000, '0, 64'h00000000ffffffff, 1'b0, '0);
    add_row(0, 6, 64'haaaaaaaaaaaaaaaa, 64'hffffffffffffffff, '0, 64'h5555555555555555, 1'b0, '0);
    add_row(0, 7, 64'h1234, 64'h1234, '0, 64'hffffffffffffffff, 1'b0, '0);
    add_row(0, 8, 64'h8000000000000000, 64'd63, '0, 64'd1, 1'b0, '0);
    add_row(0, 8, 64'h8000000000000000, 64'd0, '0, 64'h8000000000000000, 1'b0, '0);
    add_row(0, 9, 64'd1, 64'd63, '0, 64'h8000000000000000, 1'b0, '0);
    add_row(0, 9, 64'd3, 64'd0, '0, 64'd3, 1'b0, '0);
    add_row(0, 10, 64'h8000000000000000, 64'd63, '0, 64'hffffffffffffffff, 1'b0, '0);
    add_row(0, 10, 64'h8000000000000000, 64'd0, '0, 64'h8000000000000000, 1'b0, '0);
    add_row(0, 10, 64'hffffffffffffff00, 64'd4, '0, 64'hfffffffffffffff0, 1'b0, '0);
    add_row(0, 10, 64'h7fffffffffffffff, 64'd63, '0, '0, 1'b0, '0);        // Positive fills 0
    add_row(0, 11, 64'd1, 64'h8000000000000000, '0, 64'd1, 1'b0, '0);      // Sign boundary
    add_row(0, 14, 64'd1, 64'h8000000000000000, '0, 64'd0, 1'b0, '0);
    add_row(0, 11, 64'hffffffffffffffff, '0, '0, 64'd0, 1'b0, '0);
    add_row(0, 14, 64'hffffffffffffffff, '0, '0, 64'd1, 1'b0, '0);
    add_row(0, 12, 64'd42, 64'd42, '0, 64'd1, 1'b0, '0);
    add_row(0, 12, 64'd42, 64'd43, '0, 64'd0, 1'b0, '0);
    add_row(0, 13, 64'd7, 64'd7, '0, 64'd1, 1'b0, '0);
    add_row(0, 15, 64'h8000000000000000, 64'h7fffffffffffffff, '0, 64'd1, 1'b0, '0);
    add_row(0, 13, 64'h8000000000000000, 64'h7fffffffffffffff, '0, 64'd0, 1'b0, '0);
    add_row(0, 20, 64'd1, 64'd2, '0, 64'hdeadbeefbaadbeef, 1'b0, '0);      // Undefined code
    // Multiplier, low 64 bits
    add_row(1, 0, 64'd3, 64'd5, '0, 64'd15, 1'b0, '0);
    add_row(1, 0, 64'hffffffffffffffff, 64'd2, '0, 64'hfffffffffffffffe, 1'b0, '0);
    add_row(1, 0, 64'h100000000, 64'h100000000, '0, '0, 1'b0, '0);
    add_row(1, 0, 64'h12345678, 64'h1000, '0, 64'h12345678000, 1'b0, '0);
    add_row(1, 0, 64'hffffffffffffffff, 64'hffffffffffffffff, '0, 64'd1, 1'b0, '0);
    // Branch: opa, pc, disp, link, taken, target
    add_row(2, 0, '0, 64'h1000, 64'd4, 64'h1004, 1'b1, 64'h1014);
    add_row(2, 4, 64'd1, 64'h1000, 64'd4, 64'h1004, 1'b1, 64'h1014);
    add_row(2, 1, '0, 64'h1000, 64'd4, 64'h1004, 1'b1, 64'h1014);
    add_row(2, 5, '0, 64'h1000, 64'd4, 64'h1004, 1'b0, 64'h1014);
    add_row(2, 2, 64'hffffffffffffffff, 64'h1000, 64'd4, 64'h1004, 1'b1, 64'h1014);
    add_row(2, 6, '0, 64'h1000, 64'd4, 64'h1004, 1'b1, 64'h1014);
    add_row(2, 6, 64'h8000000000000000, 64'h1000, 64'd4, 64'h1004, 1'b0, 64'h1014);
    add_row(2, 3, '0, 64'h1000, 64'd4, 64'h1004, 1'b1, 64'h1014);
    add_row(2, 3, 64'd5, 64'h1000, 64'd4, 64'h1004, 1'b0, 64'h1014);
    add_row(2, 7, 64'd5, 64'h1000, 64'd4, 64'h1004, 1'b1, 64'h1014);
    add_row(2, 7, 64'hffffffffffffffff, 64'h2000, 64'hfffffffffffffffe, 64'h2004, 1'b0, 64'h1ffc);

    limit = (rows.size() + NUM_RANDOM) * (MULT_STAGES + N + 4) + 200;

    repeat (10) @(negedge clock);
    rst_n = 1'b1;
    repeat (3) next_cycle();  // Idle window after reset

    foreach (rows[i])
      issue_op(rows[i].unit, rows[i].func, rows[i].a, rows[i].b, rows[i].disp,
               rows[i].ev, rows[i].et, rows[i].eg);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      rng  = xorshift(rng);
      unit = int'(rng[9:0] % 10'd3);
      rng  = xorshift(rng);
      a    = rng;
      rng  = xorshift(rng);
      b    = rng;
      rng  = xorshift(rng);
      d    = {{48{rng[31]}}, rng[31:16]};  // Small signed displacement
      if (unit == fu_pkg::UNIT_ALU) begin
        f = 5'(rng[7:0] % 8'd18);  // 16 and 17 are undefined
        if (rng[9:8] == 2'd0)
          b = a;                   // Equal compare operands
        issue_op(unit, f, a, b, '0, alu_model(f, a, b), 1'b0, '0);
      end else if (unit == fu_pkg::UNIT_MULT) begin
        issue_op(unit, 5'd0, a, b, '0, a * b, 1'b0, '0);
      end else begin
        f = {2'b00, rng[2:0]};
        case (rng[5:3])
          3'd0: a = '0;
          3'd1: a = 64'd1;
          3'd2: a = 64'hffffffffffffffff;
          3'd3: a = 64'h8000000000000000;
          default: a = {1'b0, a[62:0]};  // Positive
        endcase
        b  = b & ~64'd3;  // Aligned pc
        ev = b + 64'd4;
        et = br_model(f[2:0], a);
        eg = b + 64'd4 + d * 64'd4;
        issue_op(unit, f, a, b, d, ev, et, eg);
      end
    end
    next_cycle();

    for (int i = 0; i < 100 && n_pending != 0; i++)
      @(negedge clock);
    if (n_pending != 0 || n_done != n_issued) begin
      fail_run($sformatf("%0d results still outstanding at the end", n_pending));
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

// ==== tb.f ====
fu_pkg.sv
alu.sv
mult_unit.sv
branch_unit.sv
cdb_arbiter.sv
fu_cluster.sv
tb_fu_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fu_cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f tb.f \
  --top-module tb_fu_cluster \
  -Mdir obj_dir \
  -o sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
